/* flist.f */
tg_pkg.sv
phase_counter.sv
frame_fsm.sv
fot_sequencer.sv
line_readout_sequencer.sv
sensor_timing_top.sv
sensor_timing_assertions.sv
tb_sensor_timing.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sensor_timing -f flist.f

./obj_dir/Vtb_sensor_timing > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation run ok"
else
  echo "simulation run failed, see sim.log"
  exit 1
fi

/* tb_sensor_timing.sv */
module tb_sensor_timing
  import tg_pkg::*;
();

  localparam int WAIT_LIMIT = 20000;

  logic      dig_clk;
  logic      rst;
  logic      frame_reg;
  logic      bit_mode;
  exp_time_t exp_time;
  row_cnt_t  num_rows;
  logic      inte;
  logic      fot;
  logic      rowdec_pc;
  logic      rowdec_s1;
  logic      rowdec_tx;
  logic      pga_rst;
  logic      rowdec_rd_en;
  logic      rowdec_clk_rd;
  logic      adc_en_ramp;
  logic      adc_store;
  row_cnt_t  row_addr;

  sensor_timing_top sensor_timing_top_inst (.*);

  initial begin
    dig_clk = 1'b0;
    forever #20 dig_clk = ~dig_clk;
  end

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic logic level_of(input string name);
    return (name == "fot") ? fot : (name == "rowdec_rd_en") ? rowdec_rd_en : inte;
  endfunction

  task automatic wait_level(input string name, input logic level);
    int n;
    n = 0;
    while (level_of(name) !== level) begin
      @(negedge dig_clk);
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout({name, " to change level"});
      end
    end
  endtask

  // one-cycle request, returns on the falling edge after it was sampled
  task automatic pulse_frame();
    frame_reg = 1'b1;
    @(negedge dig_clk);
    frame_reg = 1'b0;
  endtask

  task automatic choose_setup(input logic mode);
    bit_mode = mode;
    exp_time = exp_time_t'($urandom_range(64, 1));
    num_rows = row_cnt_t'($urandom_range(4, 1));
  endtask

  // j counts fot cycles, strobes trail the count by one cycle
  task automatic fot_strobes_ok(input int j);
    int   c;
    logic act;
    act = (j >= 1) && (j <= FOT_LEN);
    c   = j - 1;
    expect_equal("rowdec_pc", rowdec_pc, act && (c < FOT_PC_OFF));
    expect_equal("rowdec_s1", rowdec_s1, act && (c >= FOT_S1_ON) && (c < FOT_S1_OFF));
    expect_equal("rowdec_tx", rowdec_tx, act && (c >= FOT_TX_ON) && (c < FOT_TX_OFF));
    expect_equal("pga_rst", pga_rst,
                 act && (c >= FOT_PGA_RST_ON) && (c < FOT_PGA_RST_OFF));
  endtask

  task automatic line_strobes_ok(input int j, input int total);
    int   len;
    int   c;
    logic act;
    len = bit_mode ? LINE_LEN_12 : LINE_LEN_10;
    act = (j >= 1) && (j <= total);
    c   = (j - 1) % len;
    expect_equal("rowdec_clk_rd", rowdec_clk_rd, act && (c < LINE_CLK_RD_LEN));
    if (bit_mode) begin
      expect_equal("pga_rst", pga_rst, act && (c < LINE_PGA_RST_OFF_12));
      expect_equal("adc_en_ramp", adc_en_ramp,
                   act && (c >= LINE_RAMP_ON_12) && (c < LINE_RAMP_OFF_12));
      expect_equal("adc_store", adc_store, act && (c == LINE_STORE_12));
    end else begin
      expect_equal("pga_rst", pga_rst, act && (c < LINE_PGA_RST_OFF_10));
      expect_equal("adc_en_ramp", adc_en_ramp,
                   act && (c >= LINE_RAMP_ON_10) && (c < LINE_RAMP_OFF_10));
      expect_equal("adc_store", adc_store, act && (c == LINE_STORE_10));
    end
  endtask

  task automatic reset_outputs_zero();
    expect_equal("inte", inte, 0);
    expect_equal("fot", fot, 0);
    expect_equal("rowdec_pc", rowdec_pc, 0);
    expect_equal("rowdec_s1", rowdec_s1, 0);
    expect_equal("rowdec_tx", rowdec_tx, 0);
    expect_equal("pga_rst", pga_rst, 0);
    expect_equal("rowdec_rd_en", rowdec_rd_en, 0);
    expect_equal("rowdec_clk_rd", rowdec_clk_rd, 0);
    expect_equal("adc_en_ramp", adc_en_ramp, 0);
    expect_equal("adc_store", adc_store, 0);
    expect_equal("row_addr", row_addr, 0);
  endtask

  task automatic exposure_width();
    int lead;
    int width;
    choose_setup(1'b0);
    pulse_frame();
    lead = 0;
    while (!inte) begin
      @(negedge dig_clk);
      lead++;
      if (lead > WAIT_LIMIT) begin
        report_timeout("inte to rise");
      end
    end
    expect_equal("inte lead", lead, EXPOSE_LEAD);
    width = 0;
    while (inte) begin
      width++;
      @(negedge dig_clk);
      if (width > WAIT_LIMIT) begin
        report_timeout("inte to fall");
      end
    end
    expect_equal("inte width", width, exp_time);
    expect_equal("fot", fot, 1);
    wait_level("rowdec_rd_en", 1'b1);
    wait_level("rowdec_rd_en", 1'b0);
  endtask

  task automatic fot_windows();
    int j;
    choose_setup(1'b0);
    pulse_frame();
    wait_level("fot", 1'b1);
    j = 0;
    while (fot) begin
      fot_strobes_ok(j);
      @(negedge dig_clk);
      j++;
      if (j > WAIT_LIMIT) begin
        report_timeout("fot to fall");
      end
    end
    expect_equal("fot length", j, FOT_LEN);
    fot_strobes_ok(j);
    wait_level("rowdec_rd_en", 1'b0);
  endtask

  task automatic readout_lines(input logic mode);
    int len;
    int total;
    int j;
    choose_setup(mode);
    len   = mode ? LINE_LEN_12 : LINE_LEN_10;
    total = num_rows * len;
    pulse_frame();
    wait_level("rowdec_rd_en", 1'b1);
    j = 0;
    while (rowdec_rd_en) begin
      line_strobes_ok(j, total);
      expect_equal("row_addr", row_addr, j / len);
      @(negedge dig_clk);
      j++;
      if (j > WAIT_LIMIT) begin
        report_timeout("rowdec_rd_en to fall");
      end
    end
    expect_equal("rowdec_rd_en length", j, total);
    line_strobes_ok(j, total);
    expect_equal("row_addr", row_addr, 0);
  endtask

  task automatic busy_frame_ignored();
    int n;
    int inte_cycles;
    choose_setup(1'b0);
    pulse_frame();
    wait_level("fot", 1'b1);
    // stray request in the first fot cycle
    pulse_frame();
    n           = 1;
    inte_cycles = 0;
    while (fot || rowdec_rd_en) begin
      if (inte) begin
        inte_cycles++;
      end
      @(negedge dig_clk);
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout("the busy frame to end");
      end
    end
    expect_equal("frame length", n, FOT_LEN + num_rows * LINE_LEN_10);
    expect_equal("inte cycles", inte_cycles, 0);
    repeat (EXPOSE_LEAD + 2) begin
      @(negedge dig_clk);
      expect_equal("inte", inte, 0);
    end
  endtask

  initial begin
    void'($urandom(48700));
    rst       = 1'b0;
    frame_reg = 1'b0;
    bit_mode  = 1'b0;
    exp_time  = 16'd1;
    num_rows  = 8'd1;
    repeat (4) @(negedge dig_clk);
    rst = 1'b1;
    @(negedge dig_clk);
    reset_outputs_zero();
    exposure_width();
    fot_windows();
    readout_lines(1'b0);
    readout_lines(1'b1);
    busy_frame_ignored();
    $display("test passed");
    $finish;
  end

endmodule

/* sensor_timing_assertions.sv */
module sensor_timing_assertions
  import tg_pkg::*;
(
  input logic dig_clk,
  input logic rst,
  input logic frame_reg,
  input logic inte,
  input logic fot,
  input logic rowdec_rd_en,
  input logic adc_store
);

  // cycles of the current fot pulse so far
  logic [15:0] fot_run;

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      fot_run <= '0;
    end else if (fot) begin
      fot_run <= fot_run + 16'd1;
    end else begin
      fot_run <= '0;
    end
  end

  // inte register updates on the lead edge, seen one sample later
  inte_lead_a: assert property (@(posedge dig_clk) disable iff (!rst)
    $rose(inte) |-> $past(frame_reg, EXPOSE_LEAD + 1))
    else $error("inte rose without a frame request %0d cycles before", EXPOSE_LEAD);

  fot_len_a: assert property (@(posedge dig_clk) disable iff (!rst)
    $fell(fot) |-> (fot_run == FOT_LEN))
    else $error("fot pulse ended after %0d cycles", fot_run);

  fot_max_a: assert property (@(posedge dig_clk) disable iff (!rst)
    fot |-> (fot_run < FOT_LEN))
    else $error("fot pulse longer than the frame overhead time");

  store_in_readout_a: assert property (@(posedge dig_clk) disable iff (!rst)
    adc_store |-> rowdec_rd_en)
    else $error("adc_store high outside readout");

endmodule

bind sensor_timing_top sensor_timing_assertions sensor_timing_assertions_inst (
  .dig_clk      (dig_clk),
  .rst          (rst),
  .frame_reg    (frame_reg),
  .inte         (inte),
  .fot          (fot),
  .rowdec_rd_en (rowdec_rd_en),
  .adc_store    (adc_store)
);

/* sensor_timing_top.sv */
module sensor_timing_top
  import tg_pkg::*;
(
  input  logic      dig_clk,
  input  logic      rst,
  input  logic      frame_reg,
  input  logic      bit_mode,
  input  exp_time_t exp_time,
  input  row_cnt_t  num_rows,
  output logic      inte,
  output logic      fot,
  output logic      rowdec_pc,
  output logic      rowdec_s1,
  output logic      rowdec_tx,
  output logic      pga_rst,
  output logic      rowdec_rd_en,
  output logic      rowdec_clk_rd,
  output logic      adc_en_ramp,
  output logic      adc_store,
  output row_cnt_t  row_addr
);

  logic       phase_start;
  logic       line_start;
  phase_cnt_t phase_cnt;
  logic       fot_pga_rst;
  logic       line_pga_rst;

  frame_fsm frame_fsm_inst (
    .dig_clk      (dig_clk),
    .rst          (rst),
    .frame_reg    (frame_reg),
    .bit_mode     (bit_mode),
    .exp_time     (exp_time),
    .num_rows     (num_rows),
    .phase_cnt    (phase_cnt),
    .phase_start  (phase_start),
    .line_start   (line_start),
    .inte         (inte),
    .fot          (fot),
    .rowdec_rd_en (rowdec_rd_en),
    .row_addr     (row_addr)
  );

  phase_counter phase_counter_inst (
    .dig_clk     (dig_clk),
    .rst         (rst),
    .phase_start (phase_start),
    .line_start  (line_start),
    .phase_cnt   (phase_cnt)
  );

  fot_sequencer fot_sequencer_inst (
    .dig_clk     (dig_clk),
    .rst         (rst),
    .fot         (fot),
    .phase_cnt   (phase_cnt),
    .rowdec_pc   (rowdec_pc),
    .rowdec_s1   (rowdec_s1),
    .rowdec_tx   (rowdec_tx),
    .fot_pga_rst (fot_pga_rst)
  );

  line_readout_sequencer line_readout_sequencer_inst (
    .dig_clk       (dig_clk),
    .rst           (rst),
    .rowdec_rd_en  (rowdec_rd_en),
    .bit_mode      (bit_mode),
    .phase_cnt     (phase_cnt),
    .rowdec_clk_rd (rowdec_clk_rd),
    .line_pga_rst  (line_pga_rst),
    .adc_en_ramp   (adc_en_ramp),
    .adc_store     (adc_store)
  );

  // one amplifier reset pin shared by FOT and readout
  assign pga_rst = fot_pga_rst || line_pga_rst;

endmodule

/* line_readout_sequencer.sv */
module line_readout_sequencer
  import tg_pkg::*;
(
  input  logic       dig_clk,
  input  logic       rst,
  input  logic       rowdec_rd_en,
  input  logic       bit_mode,
  input  phase_cnt_t phase_cnt,
  output logic       rowdec_clk_rd,
  output logic       line_pga_rst,
  output logic       adc_en_ramp,
  output logic       adc_store
);

  phase_cnt_t pga_rst_off;
  phase_cnt_t ramp_on;
  phase_cnt_t ramp_off;
  phase_cnt_t store_at;

  logic clk_rd_win;
  logic pga_win;
  logic ramp_win;
  logic store_hit;

  // window set for the selected conversion depth
  assign pga_rst_off = bit_mode ? LINE_PGA_RST_OFF_12 : LINE_PGA_RST_OFF_10;
  assign ramp_on     = bit_mode ? LINE_RAMP_ON_12     : LINE_RAMP_ON_10;
  assign ramp_off    = bit_mode ? LINE_RAMP_OFF_12    : LINE_RAMP_OFF_10;
  assign store_at    = bit_mode ? LINE_STORE_12       : LINE_STORE_10;

  assign clk_rd_win = (phase_cnt < LINE_CLK_RD_LEN);
  assign pga_win    = (phase_cnt < pga_rst_off);
  assign ramp_win   = (phase_cnt >= ramp_on) && (phase_cnt < ramp_off);

  // latch counter values right after the ramp
  assign store_hit  = (phase_cnt == store_at);

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      rowdec_clk_rd <= 1'b0;
      line_pga_rst  <= 1'b0;
      adc_en_ramp   <= 1'b0;
      adc_store     <= 1'b0;
    end else if (!rowdec_rd_en) begin
      rowdec_clk_rd <= 1'b0;
      line_pga_rst  <= 1'b0;
      adc_en_ramp   <= 1'b0;
      adc_store     <= 1'b0;
    end else begin
      rowdec_clk_rd <= clk_rd_win;
      line_pga_rst  <= pga_win;
      adc_en_ramp   <= ramp_win;
      adc_store     <= store_hit;
    end
  end

endmodule

/* fot_sequencer.sv */
module fot_sequencer
  import tg_pkg::*;
(
  input  logic       dig_clk,
  input  logic       rst,
  input  logic       fot,
  input  phase_cnt_t phase_cnt,
  output logic       rowdec_pc,
  output logic       rowdec_s1,
  output logic       rowdec_tx,
  output logic       fot_pga_rst
);

  logic pc_win;
  logic s1_win;
  logic tx_win;
  logic pga_win;

  // precharge runs from the start of FOT
  assign pc_win = (phase_cnt < FOT_PC_OFF);

  // row select, then charge transfer inside it
  assign s1_win = (phase_cnt >= FOT_S1_ON) && (phase_cnt < FOT_S1_OFF);
  assign tx_win = (phase_cnt >= FOT_TX_ON) && (phase_cnt < FOT_TX_OFF);

  // amplifier reset near the end of FOT
  assign pga_win = (phase_cnt >= FOT_PGA_RST_ON) && (phase_cnt < FOT_PGA_RST_OFF);

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      rowdec_pc   <= 1'b0;
      rowdec_s1   <= 1'b0;
      rowdec_tx   <= 1'b0;
      fot_pga_rst <= 1'b0;
    end else if (!fot) begin
      rowdec_pc   <= 1'b0;
      rowdec_s1   <= 1'b0;
      rowdec_tx   <= 1'b0;
      fot_pga_rst <= 1'b0;
    end else begin
      rowdec_pc   <= pc_win;
      rowdec_s1   <= s1_win;
      rowdec_tx   <= tx_win;
      fot_pga_rst <= pga_win;
    end
  end

endmodule

/* frame_fsm.sv */
module frame_fsm
  import tg_pkg::*;
(
  input  logic       dig_clk,
  input  logic       rst,
  input  logic       frame_reg,
  input  logic       bit_mode,
  input  exp_time_t  exp_time,
  input  row_cnt_t   num_rows,
  input  phase_cnt_t phase_cnt,
  output logic       phase_start,
  output logic       line_start,
  output logic       inte,
  output logic       fot,
  output logic       rowdec_rd_en,
  output row_cnt_t   row_addr
);

  frame_state_t state;
  frame_state_t state_nxt;

  // frame request delay, sets the lead to inte
  logic [EXPOSE_LEAD-1:0] req_pipe;

  // upper exposure bits beyond the shared counter
  logic [$bits(exp_time_t)-$bits(phase_cnt_t)-1:0] exp_hi;

  phase_cnt_t line_len;
  logic       req_take;
  logic       exp_done;
  logic       fot_done;
  logic       line_done;
  logic       last_row;

  assign line_len  = bit_mode ? LINE_LEN_12 : LINE_LEN_10;
  assign exp_done  = ({exp_hi, phase_cnt} == exp_time_t'(exp_time - 16'd1));
  assign fot_done  = (phase_cnt == FOT_LEN - 12'd1);
  assign line_done = (phase_cnt == line_len - 12'd1);
  assign last_row  = (row_addr == num_rows - 8'd1);

  // only one request in flight, and only from idle
  assign req_take = frame_reg && (state == st_idle) && (req_pipe == '0);

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      req_pipe <= '0;
    end else begin
      req_pipe <= {req_pipe[EXPOSE_LEAD-2:0], req_take};
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (req_pipe[EXPOSE_LEAD-1]) begin
          state_nxt = st_expose;
        end
      end
      st_expose: begin
        if (exp_done) begin
          state_nxt = st_fot;
        end
      end
      st_fot: begin
        if (fot_done) begin
          state_nxt = st_readout;
        end
      end
      st_readout: begin
        if (line_done && last_row) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // held in idle so the counter parks at zero
  assign phase_start = (state == st_idle) || (state_nxt != state);
  assign line_start  = (state == st_readout) && line_done && !last_row;

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      state        <= st_idle;
      inte         <= 1'b0;
      fot          <= 1'b0;
      rowdec_rd_en <= 1'b0;
    end else begin
      state        <= state_nxt;
      inte         <= (state_nxt == st_expose);
      fot          <= (state_nxt == st_fot);
      rowdec_rd_en <= (state_nxt == st_readout);
    end
  end

  // carry out of the 12-bit count while exposing
  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      exp_hi <= '0;
    end else if (state != st_expose) begin
      exp_hi <= '0;
    end else if (phase_cnt == '1) begin
      exp_hi <= exp_hi + 1'b1;
    end
  end

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      row_addr <= '0;
    end else if (line_start) begin
      row_addr <= row_addr + 8'd1;
    end else if (state_nxt != st_readout) begin
      row_addr <= '0;
    end
  end

endmodule

/* phase_counter.sv */
module phase_counter
  import tg_pkg::*;
(
  input  logic       dig_clk,
  input  logic       rst,
  input  logic       phase_start,
  input  logic       line_start,
  output phase_cnt_t phase_cnt
);

  logic restart;

  // either strobe starts a new count on the next cycle
  assign restart = phase_start || line_start;

  always_ff @(posedge dig_clk) begin
    if (!rst) begin
      phase_cnt <= '0;
    end else if (restart) begin
      phase_cnt <= '0;
    end else begin
      // free running, wraps during long exposures
      phase_cnt <= phase_cnt + 12'd1;
    end
  end

endmodule

/* tg_pkg.sv */
package tg_pkg;

  // exposure length in dig_clk cycles
  typedef logic [15:0] exp_time_t;

  // row address or row count
  typedef logic [7:0] row_cnt_t;

  // cycle count inside a phase or a line
  typedef logic [11:0] phase_cnt_t;

  typedef enum logic [1:0] {
    st_idle,
    st_expose,
    st_fot,
    st_readout
  } frame_state_t;

  // cycles from a sampled frame_reg to inte rising
  localparam int EXPOSE_LEAD = 2;

  // FOT windows, counted from the first fot cycle
  localparam phase_cnt_t FOT_LEN         = 12'd3120;
  localparam phase_cnt_t FOT_PC_OFF      = 12'd2352;
  localparam phase_cnt_t FOT_S1_ON       = 12'd240;
  localparam phase_cnt_t FOT_S1_OFF      = 12'd2160;
  localparam phase_cnt_t FOT_TX_ON       = 12'd1440;
  localparam phase_cnt_t FOT_TX_OFF      = 12'd1920;
  localparam phase_cnt_t FOT_PGA_RST_ON  = 12'd2710;
  localparam phase_cnt_t FOT_PGA_RST_OFF = 12'd2910;

  // row clock width, same for both modes
  localparam phase_cnt_t LINE_CLK_RD_LEN = 12'd24;

  // 10-bit line
  localparam phase_cnt_t LINE_PGA_RST_OFF_10 = 12'd38;
  localparam phase_cnt_t LINE_RAMP_ON_10     = 12'd15;
  localparam phase_cnt_t LINE_RAMP_OFF_10    = 12'd126;
  localparam phase_cnt_t LINE_STORE_10       = 12'd127;
  localparam phase_cnt_t LINE_LEN_10         = 12'd129;

  // 12-bit line, longer ramp
  localparam phase_cnt_t LINE_PGA_RST_OFF_12 = 12'd192;
  localparam phase_cnt_t LINE_RAMP_ON_12     = 12'd44;
  localparam phase_cnt_t LINE_RAMP_OFF_12    = 12'd414;
  localparam phase_cnt_t LINE_STORE_12       = 12'd415;
  localparam phase_cnt_t LINE_LEN_12         = 12'd417;

endpackage
